// ==== sim.f ====
stream_pkg.sv
pix_stream_if.sv
route_latch.sv
stream_interconnect.sv
pixel_switch_top.sv
tb_pixel_switch.sv

// ==== Makefile ====
# Verilator build for the pixel stream switch

VERILATOR  ?= verilator
TB_TOP     ?= tb_pixel_switch
RTL_TOP    ?= pixel_switch_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
RTL_SRCS   ?= stream_pkg.sv pix_stream_if.sv route_latch.sv \
              stream_interconnect.sv pixel_switch_top.sv
TB_SRCS    ?= tb_pixel_switch.sv
FAIL_MSG   := ** FAIL **

SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi; \
	if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_pixel_switch.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pixel_switch;
	import stream_pkg::*;

	localparam int LINES       = 3;
	localparam int WIDTH       = 6;
	localparam int FRAME_BEATS = LINES * WIDTH;
	localparam int TIMEOUT     = 1000;
	localparam int SEED        = 25;

	// Expected beat as {user, last, pixel}
	typedef logic [PIXEL_WIDTH+1:0] beat_t;

	logic                 clk;
	logic                 resetn;
	logic [SRC_NUM-1:0]   s_valid;
	pixel_t               s_data [SRC_NUM];
	logic [SRC_NUM-1:0]   s_user;
	logic [SRC_NUM-1:0]   s_last;
	logic [SRC_NUM-1:0]   s_ready;
	dst_bmp_t             s_dst  [SRC_NUM];
	logic [DST_NUM-1:0]   m_valid;
	pixel_t               m_data [DST_NUM];
	logic [DST_NUM-1:0]   m_user;
	logic [DST_NUM-1:0]   m_last;
	logic [DST_NUM-1:0]   m_ready;

	beat_t       exp_q [DST_NUM][$];
	dst_bmp_t    model_bmp [SRC_NUM];
	int          errors;
	int          timeouts;
	int          beats_checked;
	int          tests_run;

	pixel_switch_top UUT (
		.clk     (clk),
		.resetn  (resetn),
		.s_valid (s_valid),
		.s_data  (s_data),
		.s_user  (s_user),
		.s_last  (s_last),
		.s_ready (s_ready),
		.s_dst   (s_dst),
		.m_valid (m_valid),
		.m_data  (m_data),
		.m_user  (m_user),
		.m_last  (m_last),
		.m_ready (m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Does a frame with this bitmap reach the given sink
	function automatic bit route_of(input dst_bmp_t bmp, input int sink);
		return bmp[sink];
	endfunction

	// Reference model fed by source beats seen at the DUT ports
	always @(posedge clk) begin
		dst_bmp_t cur;
		if (!resetn) begin
			for (int s = 0; s < SRC_NUM; s++) begin
				model_bmp[s] = '0;
			end
		end else begin
			for (int s = 0; s < SRC_NUM; s++) begin
				if (s_valid[s]) begin
					cur = s_user[s] ? s_dst[s] : model_bmp[s];
					if (cur == '0) begin
						assert (s_ready[s])
						else begin
							$display("[FAIL] %0t source %0d stalled with an empty route", $time, s);
							errors++;
						end
					end
					if (s_ready[s]) begin
						if (s_user[s]) begin
							model_bmp[s] = cur;
						end
						for (int d = 0; d < DST_NUM; d++) begin
							if (route_of(cur, d)) begin
								exp_q[d].push_back({s_user[s], s_last[s], s_data[s]});
							end
						end
					end
				end
			end
		end
	end

	// Compare every sink beat with the model
	always @(posedge clk) begin
		beat_t got;
		beat_t want;
		if (resetn) begin
			for (int d = 0; d < DST_NUM; d++) begin
				if (m_valid[d] && m_ready[d]) begin
					got = {m_user[d], m_last[d], m_data[d]};
					assert (exp_q[d].size() > 0)
					else begin
						$display("Sink %0d delivered a beat that no source sent", d);
						errors++;
					end
					if (exp_q[d].size() > 0) begin
						want = exp_q[d].pop_front();
						beats_checked++;
						assert (got == want)
						else begin
							$display("[FAIL] %0t sink %0d got %h, expected %h", $time, d, got, want);
							errors++;
						end
					end
				end
			end
		end
	end

	// One frame of random pixels with an optional late s_dst change
	task automatic send_frame(input int src, input dst_bmp_t bmp, input dst_bmp_t late_bmp,
			input int change_at);
		int cycles;
		@(posedge clk);
		s_dst[src] <= bmp;
		for (int beat = 0; beat < FRAME_BEATS; beat++) begin
			if (beat == change_at) begin
				s_dst[src] <= late_bmp;
			end
			s_valid[src] <= 1'b1;
			s_data[src]  <= pixel_t'($urandom);
			s_user[src]  <= (beat == 0);
			s_last[src]  <= (beat % WIDTH == WIDTH - 1);
			cycles = 0;
			do begin
				@(posedge clk);
				cycles++;
			end while (!s_ready[src] && cycles < TIMEOUT);
			if (!s_ready[src]) begin
				$display("Timeout: source %0d was never ready for beat %0d", src, beat);
				timeouts++;
				break;
			end
		end
		s_valid[src] <= 1'b0;
		s_user[src]  <= 1'b0;
		s_last[src]  <= 1'b0;
	endtask

	task automatic random_backpressure(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			m_ready <= dst_bmp_t'($urandom);
		end
		@(posedge clk);
		m_ready <= '1;
	endtask

	task automatic wait_drain();
		int cycles;
		bit busy;
		cycles = 0;
		busy = 1'b1;
		while (busy && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
			busy = (m_valid != '0) || (s_valid != '0);
			for (int d = 0; d < DST_NUM; d++) begin
				if (exp_q[d].size() != 0) begin
					busy = 1'b1;
				end
			end
		end
		if (busy) begin
			$display("Timeout: sinks still owe beats after %0d cycles", cycles);
			timeouts++;
		end
	endtask

	task automatic report_test(input string name, input int bad_before);
		tests_run++;
		if (errors + timeouts == bad_before) begin
			$display("Test %s: ok", name);
		end else begin
			$display("Test %s: %0d problems", name, errors + timeouts - bad_before);
		end
	endtask

	initial begin
		int bad;
		void'($urandom(SEED));
		errors = 0;
		timeouts = 0;
		beats_checked = 0;
		tests_run = 0;
		resetn = 1'b0;
		s_valid = '0;
		s_user = '0;
		s_last = '0;
		m_ready = '1;
		for (int s = 0; s < SRC_NUM; s++) begin
			s_data[s] = '0;
			s_dst[s] = '0;
		end
		repeat (5) @(posedge clk);
		resetn <= 1'b1;

		bad = errors + timeouts;
		repeat (3) begin
			@(posedge clk);
			assert (m_valid == '0)
			else begin
				$display("[FAIL] %0t sink valid high after reset: %b", $time, m_valid);
				errors++;
			end
			assert (s_ready == '1)
			else begin
				$display("[FAIL] %0t source ready low while idle: %b", $time, s_ready);
				errors++;
			end
		end
		report_test("reset", bad);

		// Source s to sink 3-s all at once
		bad = errors + timeouts;
		fork
			send_frame(0, 4'b1000, 4'b1000, -1);
			send_frame(1, 4'b0100, 4'b0100, -1);
			send_frame(2, 4'b0010, 4'b0010, -1);
			send_frame(3, 4'b0001, 4'b0001, -1);
		join
		wait_drain();
		report_test("unicast", bad);

		bad = errors + timeouts;
		send_frame(1, '1, '1, -1);
		wait_drain();
		report_test("broadcast", bad);

		bad = errors + timeouts;
		fork
			send_frame(1, '1, '1, -1);
			random_backpressure(60);
		join
		wait_drain();
		report_test("backpressure", bad);

		// Route change mid-frame waits for the next start of frame
		bad = errors + timeouts;
		send_frame(0, 4'b0001, 4'b0100, 7);
		send_frame(0, 4'b0100, 4'b0100, -1);
		wait_drain();
		report_test("frame_routing", bad);

		// Stalled sinks must not hold back a source that routes nowhere
		bad = errors + timeouts;
		fork
			send_frame(2, '0, '0, -1);
			send_frame(3, 4'b0001, 4'b0001, -1);
			random_backpressure(40);
		join
		wait_drain();
		report_test("empty_bitmap", bad);

		$display("Tests %0d, beats checked %0d, errors %0d, timeouts %0d",
			tests_run, beats_checked, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== pixel_switch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_switch_top (
	input  logic                         clk,
	input  logic                         resetn,

	// Source streams, indexed by source
	input  logic [stream_pkg::SRC_NUM-1:0] s_valid,
	input  stream_pkg::pixel_t             s_data [stream_pkg::SRC_NUM],
	input  logic [stream_pkg::SRC_NUM-1:0] s_user,
	input  logic [stream_pkg::SRC_NUM-1:0] s_last,
	output logic [stream_pkg::SRC_NUM-1:0] s_ready,
	input  stream_pkg::dst_bmp_t           s_dst  [stream_pkg::SRC_NUM],

	// Sink streams, indexed by sink
	output logic [stream_pkg::DST_NUM-1:0] m_valid,
	output stream_pkg::pixel_t             m_data [stream_pkg::DST_NUM],
	output logic [stream_pkg::DST_NUM-1:0] m_user,
	output logic [stream_pkg::DST_NUM-1:0] m_last,
	input  logic [stream_pkg::DST_NUM-1:0] m_ready
);
	import stream_pkg::*;

	dst_bmp_t frame_bmp [SRC_NUM];

	pix_stream_if port_if   [SRC_NUM] ();
	pix_stream_if routed_if [SRC_NUM] ();
	pix_stream_if sink_if   [DST_NUM] ();

	genvar s;
	genvar d;

	generate
		for (s = 0; s < SRC_NUM; s++) begin : g_src
			assign port_if[s].valid = s_valid[s];
			assign port_if[s].data  = s_data[s];
			assign port_if[s].user  = s_user[s];
			assign port_if[s].last  = s_last[s];
			assign s_ready[s]       = port_if[s].ready;

			route_latch u_route_latch (
				.clk       (clk),
				.resetn    (resetn),
				.in        (port_if[s]),
				.out       (routed_if[s]),
				.req_bmp   (s_dst[s]),
				.frame_bmp (frame_bmp[s])
			);
		end
	endgenerate

	// Broadcast frames must reach every selected sink together
	stream_interconnect #(
		.ONE2MANY (1)
	) u_interconnect (
		.clk     (clk),
		.resetn  (resetn),
		.src     (routed_if),
		.src_bmp (frame_bmp),
		.dst     (sink_if)
	);

	generate
		for (d = 0; d < DST_NUM; d++) begin : g_dst
			assign m_valid[d]       = sink_if[d].valid;
			assign m_data[d]        = sink_if[d].data;
			assign m_user[d]        = sink_if[d].user;
			assign m_last[d]        = sink_if[d].last;
			assign sink_if[d].ready = m_ready[d];
		end
	endgenerate

endmodule

`default_nettype wire

// ==== stream_interconnect.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_interconnect #(
	parameter int ONE2MANY = 1
) (
	input  logic                 clk,
	input  logic                 resetn,
	pix_stream_if.sink           src     [stream_pkg::SRC_NUM],
	input  stream_pkg::dst_bmp_t src_bmp [stream_pkg::SRC_NUM],
	pix_stream_if.source         dst     [stream_pkg::DST_NUM]
);
	import stream_pkg::*;

	// Source side, flattened out of the interfaces
	src_bmp_t s_valid;
	src_bmp_t s_user;
	src_bmp_t s_last;
	src_bmp_t s_ready;
	src_bmp_t s_xfer;
	pixel_t   s_data [SRC_NUM];

	// Per sink view of the routing
	src_bmp_t m_src_bmp [DST_NUM];
	src_bmp_t m_hit     [DST_NUM];
	dst_bmp_t m_ready;

	// Output slots
	dst_bmp_t slot_valid;
	dst_bmp_t slot_user;
	dst_bmp_t slot_last;
	pixel_t   slot_data [DST_NUM];
	dst_bmp_t slot_free;
	dst_bmp_t load;

	// Values a slot would load this cycle
	pixel_t   mux_data [DST_NUM];
	dst_bmp_t mux_user;
	dst_bmp_t mux_last;

	genvar s;
	genvar d;

	generate
		for (s = 0; s < SRC_NUM; s++) begin : g_src
			assign s_valid[s] = src[s].valid;
			assign s_data[s]  = src[s].data;
			assign s_user[s]  = src[s].user;
			assign s_last[s]  = src[s].last;
			assign src[s].ready = s_ready[s];

			// Ready rule, an empty bitmap always drains
			if (ONE2MANY != 0) begin : g_all
				assign s_ready[s] = ((slot_free & src_bmp[s]) == src_bmp[s]);
			end else begin : g_any
				assign s_ready[s] = ((slot_free & src_bmp[s]) != '0) || (src_bmp[s] == '0);
			end
		end
	endgenerate

	assign s_xfer = s_valid & s_ready;

	generate
		for (d = 0; d < DST_NUM; d++) begin : g_dst
			// Transpose source bitmaps into the set of sources per sink
			for (s = 0; s < SRC_NUM; s++) begin : g_tr
				assign m_src_bmp[d][s] = src_bmp[s][d];
			end

			assign m_ready[d]   = dst[d].ready;
			assign m_hit[d]     = s_valid & m_src_bmp[d];
			assign slot_free[d] = !slot_valid[d] || m_ready[d];

			// Slot takes a beat only when a routed source actually transfers
			assign load[d] = slot_free[d] && ((s_xfer & m_src_bmp[d]) != '0);

			assign dst[d].valid = slot_valid[d];
			assign dst[d].data  = slot_data[d];
			assign dst[d].user  = slot_user[d];
			assign dst[d].last  = slot_last[d];

			always_ff @(posedge clk) begin
				if (!resetn) begin
					slot_valid[d] <= 1'b0;
				end else if (load[d]) begin
					slot_valid[d] <= 1'b1;
				end else if (m_ready[d]) begin
					slot_valid[d] <= 1'b0;
				end
			end

			always_ff @(posedge clk) begin
				if (load[d]) begin
					slot_data[d] <= mux_data[d];
					slot_user[d] <= mux_user[d];
					slot_last[d] <= mux_last[d];
				end
			end

			// Two sources on one sink would OR their pixels together
			assert property (@(posedge clk) disable iff (!resetn)
				$onehot0(m_hit[d]))
				else $error("stream_interconnect: several sources target sink %0d", d);

			assert property (@(posedge clk) disable iff (!resetn)
				slot_valid[d] && !m_ready[d] |=> slot_valid[d] &&
					$stable(slot_data[d]) && $stable(slot_user[d]) &&
					$stable(slot_last[d]))
				else $error("stream_interconnect: sink %0d changed a stalled beat", d);
		end
	endgenerate

	// OR over the valid sources routed to each sink
	always_comb begin
		for (int i = 0; i < DST_NUM; i++) begin
			mux_data[i] = '0;
			mux_user[i] = 1'b0;
			mux_last[i] = 1'b0;
			for (int j = 0; j < SRC_NUM; j++) begin
				if (m_hit[i][j]) begin
					mux_data[i] = mux_data[i] | s_data[j];
					mux_user[i] = mux_user[i] | s_user[j];
					mux_last[i] = mux_last[i] | s_last[j];
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== route_latch.sv ====
`timescale 1ns/1ns
`default_nettype none

module route_latch (
	input  logic                clk,
	input  logic                resetn,
	pix_stream_if.sink          in,
	pix_stream_if.source        out,
	input  stream_pkg::dst_bmp_t req_bmp,
	output stream_pkg::dst_bmp_t frame_bmp
);
	import stream_pkg::*;

	dst_bmp_t held_bmp;
	logic     sof_beat;
	logic     sof_xfer;

	// Stream passes straight through, no added latency
	assign out.valid = in.valid;
	assign out.data  = in.data;
	assign out.user  = in.user;
	assign out.last  = in.last;
	assign in.ready  = out.ready;

	assign sof_beat = in.valid && in.user;
	assign sof_xfer = sof_beat && out.ready;

	// A start-of-frame beat already routes by its own request
	assign frame_bmp = sof_beat ? req_bmp : held_bmp;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			held_bmp <= '0;
		end else if (sof_xfer) begin
			held_bmp <= req_bmp;
		end
	end

	// Upstream must hold a stalled beat, otherwise part of a frame could be misrouted
	assert property (@(posedge clk) disable iff (!resetn)
		in.valid && !in.ready |=> in.valid && $stable(in.data) &&
			$stable(in.user) && $stable(in.last))
		else $error("route_latch: stalled input beat changed before transfer");

endmodule

`default_nettype wire

// ==== pix_stream_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface pix_stream_if;
	import stream_pkg::*;

	logic   valid;
	pixel_t data;
	// Start of frame
	logic   user;
	// End of line
	logic   last;
	logic   ready;

	modport source (
		output valid,
		output data,
		output user,
		output last,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  user,
		input  last,
		output ready
	);

endinterface

`default_nettype wire

// ==== stream_pkg.sv ====
`default_nettype none

package stream_pkg;

	// Stream geometry of the switch
	localparam int PIXEL_WIDTH = 8;
	localparam int SRC_NUM     = 4;
	localparam int DST_NUM     = 4;

	// One pixel as carried by a beat
	typedef logic [PIXEL_WIDTH-1:0] pixel_t;

	// Sinks a source sends to, bit d selects sink d
	typedef logic [DST_NUM-1:0] dst_bmp_t;

	// Sources that feed one sink, bit s stands for source s
	typedef logic [SRC_NUM-1:0] src_bmp_t;

endpackage

`default_nettype wire
